/* project.f */
src/rnn_types_pkg.sv
src/rnn_fixed_pkg.sv
src/term_if.sv
src/weight_sequencer.sv
src/neuron_unit.sv
src/hidden_collector.sv
src/rnn_step_top.sv
sim/rnn_step_assert.sv
sim/tb_rnn_step.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_rnn_step \
    --Mdir obj_dir \
    -o tb_rnn_step \
    -f project.f

./obj_dir/tb_rnn_step

/* sim/rnn_step_assert.sv */
module rnn_step_assert
(
    input logic clk,
    input logic reset,
    input logic rd_en,
    input logic rd_valid,
    input logic busy,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ps;

    logic pending;   // Read issued, data not back yet

    always_ff @(posedge clk)
    begin
        if (reset)
            pending <= 1'b0;
        else if (rd_en)
            pending <= 1'b1;
        else if (rd_valid)
            pending <= 1'b0;
    end

    one_read_outstanding: assert property (
        @(posedge clk) disable iff (reset) rd_en |-> !pending
    ) else $error("rd_en raised while a read is still outstanding");

    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    ) else $error("done held high for more than one cycle");

    read_only_when_busy: assert property (
        @(posedge clk) disable iff (reset) rd_en |-> busy
    ) else $error("rd_en raised while the sequencer is idle");

endmodule

/* sim/tb_rnn_step.sv */
module tb_rnn_step
    import rnn_types_pkg::*;
    import rnn_fixed_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VOCAB_SIZE     = 76;
    localparam int EMBED_SIZE     = 4;
    localparam int HIDDEN_SIZE    = 8;
    localparam int SEL_W          = $clog2(HIDDEN_SIZE);
    localparam int IH_BASE        = VOCAB_SIZE * EMBED_SIZE;
    localparam int HH_BASE        = IH_BASE + EMBED_SIZE * HIDDEN_SIZE;
    localparam int IHB_BASE       = HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int HHB_BASE       = IHB_BASE + HIDDEN_SIZE;
    localparam int MEM_WORDS      = HHB_BASE + HIDDEN_SIZE;   // 416
    localparam int READS_PER_STEP = EMBED_SIZE + HIDDEN_SIZE * (HIDDEN_SIZE + EMBED_SIZE + 2);
    localparam int NUM_STEPS      = 7;
    localparam int CLK_PERIOD     = 10;
    localparam int WATCHDOG_NS    = NUM_STEPS * READS_PER_STEP * 6 * CLK_PERIOD + 5000;

    logic             clk = 1'b0;
    logic             reset;
    logic             execute;
    token_t           token;
    logic             rd_en;
    addr_t            rd_addr;
    word_t            rd_data;
    logic             rd_valid;
    logic             busy;
    logic             done;
    logic [SEL_W-1:0] hidden_sel;
    word_t            hidden_value;

    word_t  mem [MEM_WORDS];
    word_t  exp_state [HIDDEN_SIZE];   // Model of the committed hidden vector
    token_t pend_tok[$];
    string  pend_name[$];
    int     rd_count      = 0;
    int     checked_count = 0;
    logic   reset_checked = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rnn_step_top #(
        .VOCAB_SIZE  (VOCAB_SIZE),
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) u_rnn_step_top (
        .clk          (clk),
        .reset        (reset),
        .execute      (execute),
        .token        (token),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .busy         (busy),
        .done         (done),
        .hidden_sel   (hidden_sel),
        .hidden_value (hidden_value)
    );

    bind rnn_step_top rnn_step_assert u_rnn_step_assert (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .busy     (busy),
        .done     (done)
    );

    // One step of the network, terms summed in memory read order
    function automatic void rnn_ref_step(input token_t tok, input word_t prev [HIDDEN_SIZE],
                                         output word_t next [HIDDEN_SIZE]);
        word_t acc;
        for (int j = 0; j < HIDDEN_SIZE; j++)
        begin
            acc = '0;
            for (int k = 0; k < HIDDEN_SIZE; k++)
                acc = acc + q_mul(mem[HH_BASE + j * HIDDEN_SIZE + k], prev[k]);
            acc = acc + mem[HHB_BASE + j];
            for (int e = 0; e < EMBED_SIZE; e++)
                acc = acc + q_mul(mem[IH_BASE + j * EMBED_SIZE + e],
                                  mem[int'(tok) * EMBED_SIZE + e]);
            acc = acc + mem[IHB_BASE + j];
            next[j] = acc;
        end
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_failure($sformatf("ERROR %s expected %0d (0x%04h) actual %0d (0x%04h)",
                                     name, exp, exp, act, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("ERROR %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            report_failure($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic compare_hidden(input string name);
        for (int i = 0; i < HIDDEN_SIZE; i++)
        begin
            @(posedge clk);
            hidden_sel <= SEL_W'(i);
            @(negedge clk);
            check_word($sformatf("%s hidden[%0d]", name, i), exp_state[i], hidden_value);
        end
    endtask

    task automatic start_step(input string name, input token_t tok);
        pend_tok.push_back(tok);
        pend_name.push_back(name);
        @(posedge clk);
        execute <= 1'b1;
        token   <= tok;
        @(posedge clk);
        execute <= 1'b0;
    endtask

    // Word memory, answers each read after 1 to 4 cycles
    initial
    begin : memory_model
        int lat;
        int addr;
        rd_valid = 1'b0;
        rd_data  = '0;
        forever
        begin
            @(posedge clk);
            if (!reset && rd_en)
            begin
                addr = int'(rd_addr);
                rd_count++;
                if (addr >= MEM_WORDS)
                    report_failure($sformatf("Read address %0d lies outside the %0d-word map",
                                             addr, MEM_WORDS));
                lat = 1 + int'($urandom % 4);
                repeat (lat - 1) @(posedge clk);
                rd_data  <= mem[addr];
                rd_valid <= 1'b1;
                @(posedge clk);
                rd_valid <= 1'b0;
            end
        end
    end

    initial
    begin : compare
        word_t  next_state [HIDDEN_SIZE];
        token_t tok;
        string  name;
        int     rd_mark;
        hidden_sel = '0;
        rd_mark    = 0;
        for (int i = 0; i < HIDDEN_SIZE; i++)
            exp_state[i] = '0;
        wait (!reset);
        @(negedge clk);
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset done", 1'b0, done);
        check_bit("reset rd_en", 1'b0, rd_en);
        compare_hidden("reset");
        reset_checked = 1'b1;
        forever
        begin
            @(posedge clk);
            if (done)
            begin
                if (pend_tok.size() == 0)
                    report_failure("done pulsed although no step was started");
                tok  = pend_tok.pop_front();
                name = pend_name.pop_front();
                check_bit({name, " busy at done"}, 1'b1, busy);
                check_count({name, " reads"}, READS_PER_STEP, rd_count - rd_mark);
                rd_mark = rd_count;
                rnn_ref_step(tok, exp_state, next_state);
                exp_state = next_state;
                compare_hidden(name);
                check_bit({name, " busy after done"}, 1'b0, busy);
                checked_count++;
            end
        end
    end

    initial
    begin : stimulus
        token_t tok;
        int     first;
        reset   = 1'b1;
        execute = 1'b0;
        token   = '0;
        void'($urandom(32'h8a72_752f));
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = word_t'(int'($urandom % 1025) - 512);   // Within +-2.0
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        wait (reset_checked);

        tok = token_t'($urandom % VOCAB_SIZE);
        start_step("single_step", tok);
        wait (checked_count == 1);

        first = int'($urandom % VOCAB_SIZE);
        for (int k = 0; k < 5; k++)
        begin
            tok = token_t'((first + 13 * k) % VOCAB_SIZE);   // Five distinct tokens
            start_step($sformatf("chain_step%0d", k), tok);
            wait (checked_count == 2 + k);
        end

        tok = token_t'($urandom % VOCAB_SIZE);
        start_step("ignored_execute", tok);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bit("ignored_execute busy", 1'b1, busy);
        @(posedge clk);
        execute <= 1'b1;
        token   <= token_t'((int'(tok) + 1) % VOCAB_SIZE);
        @(posedge clk);
        execute <= 1'b0;
        wait (checked_count == NUM_STEPS);
        repeat (40) @(posedge clk);
        @(negedge clk);
        check_bit("ignored_execute idle", 1'b0, busy);

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the steps did not all finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src/hidden_collector.sv */
module hidden_collector
    import rnn_types_pkg::*;
#(
    parameter int HIDDEN_SIZE = 8,
    localparam int SEL_W = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic [HIDDEN_SIZE-1:0] result_valid,
    input  word_t                  result [HIDDEN_SIZE],

    output word_t                  state [HIDDEN_SIZE],
    output logic                   step_done,
    output logic                   done,

    input  logic [SEL_W-1:0]       hidden_sel,
    output word_t                  hidden_value
);

    word_t                  new_state [HIDDEN_SIZE];
    logic [HIDDEN_SIZE-1:0] received;
    logic                   all_in;
    logic                   done_q;

    assign all_in = &received;

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < HIDDEN_SIZE; i++)
        begin
            if (result_valid[i])
                new_state[i] <= result[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            received <= '0;
            done_q   <= 1'b0;
            for (int i = 0; i < HIDDEN_SIZE; i++)
                state[i] <= '0;
        end
        else
        begin
            done_q <= all_in;
            if (all_in)
            begin
                // Whole vector in, commit for the next step
                received <= '0;
                state    <= new_state;
            end
            else
                received <= received | result_valid;
        end
    end

    assign step_done    = done_q;
    assign done         = done_q;
    assign hidden_value = state[hidden_sel];

endmodule

/* src/neuron_unit.sv */
module neuron_unit
    import rnn_types_pkg::*;
    import rnn_fixed_pkg::*;
#(
    parameter int HIDDEN_SIZE  = 8,
    parameter int NEURON_INDEX = 0,
    localparam int HW = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
)
(
    input  logic  clk,
    input  logic  reset,
    term_if.dst   terms,
    output logic  result_valid,
    output word_t result
);

    word_t acc;
    word_t term;
    word_t sum;
    logic  hit;

    assign hit  = terms.valid && (terms.neuron == HW'(NEURON_INDEX));
    assign term = terms.is_bias ? terms.weight : q_mul(terms.weight, terms.operand);
    assign sum  = acc + term;   // Wraps like the reference

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            acc          <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= hit && terms.last;
            if (hit)
                acc <= terms.last ? word_t'(0) : sum;   // Ready for next step
        end
    end

    always_ff @(posedge clk)
    begin
        if (hit && terms.last)
            result <= sum;
    end

endmodule

/* src/rnn_fixed_pkg.sv */
package rnn_fixed_pkg;

    import rnn_types_pkg::*;

    localparam int FRAC_BITS = 8;

    // Full product, rescaled to Q8.8 and wrapped to 16 bits
    function automatic word_t q_mul(input word_t a, input word_t b);
        logic signed [2*$bits(word_t)-1:0] prod;
        prod = a * b;
        return word_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

/* src/rnn_step_top.sv */
module rnn_step_top
    import rnn_types_pkg::*;
#(
    parameter int VOCAB_SIZE  = 76,
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8,
    localparam int SEL_W = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             execute,
    input  token_t           token,

    output logic             rd_en,
    output addr_t            rd_addr,
    input  word_t            rd_data,
    input  logic             rd_valid,

    output logic             busy,
    output logic             done,

    input  logic [SEL_W-1:0] hidden_sel,
    output word_t            hidden_value
);

    word_t                  state [HIDDEN_SIZE];   // Committed hidden vector
    logic                   step_done;
    logic [HIDDEN_SIZE-1:0] result_valid;
    word_t                  result [HIDDEN_SIZE];

    term_if #(.HIDDEN_SIZE(HIDDEN_SIZE)) terms ();

    weight_sequencer #(
        .VOCAB_SIZE  (VOCAB_SIZE),
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) u_weight_sequencer (
        .clk       (clk),
        .reset     (reset),
        .execute   (execute),
        .token     (token),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .state     (state),
        .step_done (step_done),
        .busy      (busy),
        .terms     (terms)
    );

    for (genvar i = 0; i < HIDDEN_SIZE; i++)
    begin : g_neuron
        neuron_unit #(
            .HIDDEN_SIZE  (HIDDEN_SIZE),
            .NEURON_INDEX (i)
        ) u_neuron_unit (
            .clk          (clk),
            .reset        (reset),
            .terms        (terms),
            .result_valid (result_valid[i]),
            .result       (result[i])
        );
    end

    hidden_collector #(
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) u_hidden_collector (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result_valid),
        .result       (result),
        .state        (state),
        .step_done    (step_done),
        .done         (done),
        .hidden_sel   (hidden_sel),
        .hidden_value (hidden_value)
    );

endmodule

/* src/rnn_types_pkg.sv */
package rnn_types_pkg;

    // Signed Q8.8 value for weights, embeddings, hidden values and sums
    typedef logic signed [15:0] word_t;

    // Word address into the external weight memory
    typedef logic [11:0] addr_t;

    // Index into the vocabulary
    typedef logic [6:0] token_t;

    typedef enum logic [3:0] {
        IDLE,
        EMBED_REQ,
        EMBED_WAIT,
        HH_REQ,       // Hidden-to-hidden weight
        HH_WAIT,
        HHB_REQ,      // Hidden bias
        HHB_WAIT,
        IH_REQ,       // Input-to-hidden weight
        IH_WAIT,
        IHB_REQ,      // Input bias, last term of a neuron
        IHB_WAIT,
        COMMIT_WAIT
    } seq_state_t;

endpackage

/* src/term_if.sv */
interface term_if
    import rnn_types_pkg::*;
#(
    parameter int HIDDEN_SIZE = 8,
    localparam int HW = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
)
();

    logic          valid;
    logic [HW-1:0] neuron;    // Target neuron of this beat
    word_t         weight;
    word_t         operand;   // Hidden value or embedding element
    logic          is_bias;   // Term is the weight alone
    logic          last;      // Final term for this neuron

    modport src (
        output valid,
        output neuron,
        output weight,
        output operand,
        output is_bias,
        output last
    );

    modport dst (
        input valid,
        input neuron,
        input weight,
        input operand,
        input is_bias,
        input last
    );

endinterface

/* src/weight_sequencer.sv */
module weight_sequencer
    import rnn_types_pkg::*;
#(
    parameter int VOCAB_SIZE  = 76,
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8,
    localparam int EW = (EMBED_SIZE > 1) ? $clog2(EMBED_SIZE) : 1,
    localparam int HW = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   execute,
    input  token_t token,

    output logic   rd_en,
    output addr_t  rd_addr,
    input  word_t  rd_data,
    input  logic   rd_valid,

    input  word_t  state [HIDDEN_SIZE],
    input  logic   step_done,
    output logic   busy,

    term_if.src    terms
);

    // Region bases of the memory map
    localparam int IH_BASE  = VOCAB_SIZE * EMBED_SIZE;
    localparam int HH_BASE  = IH_BASE + EMBED_SIZE * HIDDEN_SIZE;
    localparam int IHB_BASE = HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int HHB_BASE = IHB_BASE + HIDDEN_SIZE;

    localparam logic [EW-1:0] EMB_LAST = EW'(EMBED_SIZE - 1);
    localparam logic [HW-1:0] HID_LAST = HW'(HIDDEN_SIZE - 1);

    seq_state_t    seq_state;
    token_t        token_q;
    word_t         emb_buf [EMBED_SIZE];
    logic [EW-1:0] emb_idx;    // Embedding element
    logic [HW-1:0] hid_idx;    // Neuron being fed
    logic [HW-1:0] term_idx;   // Hidden input of that neuron

    assign busy  = (seq_state != IDLE);
    assign rd_en = seq_state inside {EMBED_REQ, HH_REQ, HHB_REQ, IH_REQ, IHB_REQ};

    // Address held from request through the wait
    always_comb
    begin
        case (seq_state)
            EMBED_REQ, EMBED_WAIT:
                rd_addr = addr_t'(token_q * EMBED_SIZE + emb_idx);
            HH_REQ, HH_WAIT:
                rd_addr = addr_t'(HH_BASE + hid_idx * HIDDEN_SIZE + term_idx);
            HHB_REQ, HHB_WAIT:
                rd_addr = addr_t'(HHB_BASE + hid_idx);
            IH_REQ, IH_WAIT:
                rd_addr = addr_t'(IH_BASE + hid_idx * EMBED_SIZE + emb_idx);
            IHB_REQ, IHB_WAIT:
                rd_addr = addr_t'(IHB_BASE + hid_idx);
            default:
                rd_addr = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            seq_state   <= IDLE;
            emb_idx     <= '0;
            hid_idx     <= '0;
            term_idx    <= '0;
            terms.valid <= 1'b0;
        end
        else
        begin
            terms.valid <= rd_valid && (seq_state inside {HH_WAIT, HHB_WAIT, IH_WAIT, IHB_WAIT});

            case (seq_state)
                IDLE:
                begin
                    if (execute)
                    begin
                        emb_idx   <= '0;
                        hid_idx   <= '0;
                        term_idx  <= '0;
                        seq_state <= EMBED_REQ;
                    end
                end
                EMBED_REQ:   seq_state <= EMBED_WAIT;
                HH_REQ:      seq_state <= HH_WAIT;
                HHB_REQ:     seq_state <= HHB_WAIT;
                IH_REQ:      seq_state <= IH_WAIT;
                IHB_REQ:     seq_state <= IHB_WAIT;
                EMBED_WAIT:
                begin
                    if (rd_valid)
                    begin
                        if (emb_idx == EMB_LAST)
                        begin
                            emb_idx   <= '0;
                            seq_state <= HH_REQ;
                        end
                        else
                        begin
                            emb_idx   <= emb_idx + 1'b1;
                            seq_state <= EMBED_REQ;
                        end
                    end
                end
                HH_WAIT:
                begin
                    if (rd_valid)
                    begin
                        if (term_idx == HID_LAST)
                        begin
                            term_idx  <= '0;
                            seq_state <= HHB_REQ;
                        end
                        else
                        begin
                            term_idx  <= term_idx + 1'b1;
                            seq_state <= HH_REQ;
                        end
                    end
                end
                HHB_WAIT:
                begin
                    if (rd_valid)
                        seq_state <= IH_REQ;
                end
                IH_WAIT:
                begin
                    if (rd_valid)
                    begin
                        if (emb_idx == EMB_LAST)
                        begin
                            emb_idx   <= '0;
                            seq_state <= IHB_REQ;
                        end
                        else
                        begin
                            emb_idx   <= emb_idx + 1'b1;
                            seq_state <= IH_REQ;
                        end
                    end
                end
                IHB_WAIT:
                begin
                    if (rd_valid)
                    begin
                        if (hid_idx == HID_LAST)
                        begin
                            hid_idx   <= '0;
                            seq_state <= COMMIT_WAIT;
                        end
                        else
                        begin
                            hid_idx   <= hid_idx + 1'b1;
                            seq_state <= HH_REQ;
                        end
                    end
                end
                COMMIT_WAIT:
                begin
                    if (step_done)
                        seq_state <= IDLE;
                end
                default:     seq_state <= IDLE;
            endcase
        end
    end

    // Beat payload, qualified by terms.valid
    always_ff @(posedge clk)
    begin
        if (seq_state == IDLE && execute)
            token_q <= token;
        if (seq_state == EMBED_WAIT && rd_valid)
            emb_buf[emb_idx] <= rd_data;

        terms.neuron  <= hid_idx;
        terms.weight  <= rd_data;
        terms.is_bias <= (seq_state == HHB_WAIT) || (seq_state == IHB_WAIT);
        terms.last    <= (seq_state == IHB_WAIT);
        terms.operand <= (seq_state == IH_WAIT) ? emb_buf[emb_idx] : state[term_idx];
    end

endmodule
